/* all.f */
+incdir+design
design/chip8_isa_pkg.sv
design/chip8_core_pkg.sv
design/chip8_reg_if.sv
design/chip8_alu.sv
design/chip8_regfile.sv
design/chip8_sequencer.sv
design/chip8_cpu.sv
tests/chip8_props.sv
tests/chip8_tb.sv

/* tests/chip8_tb.sv */
`include "chip8_defines.svh"

module chip8_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS   = 7;
  localparam int TEST_CYCLES = 16 * `TIMER_DIV + 100; // per program
  localparam int MAX_CYCLES  = NUM_TESTS * (16 * `TIMER_DIV + 200);
  localparam int BEEP_WAIT   = 3 * `TIMER_DIV + 20;

  logic               clk_in      = 1'b0;
  logic               reset_i     = 1'b1;
  logic [`DATA_W-1:0] mem_rdata_i = '0;
  logic [`ADDR_W-1:0] mem_raddr_o;
  logic               beep_o;
  logic               halt_o;

  logic [`DATA_W-1:0] mem [4096];

  // stimulus table, one row per program
  logic [15:0]        prog_tab [NUM_TESTS][16];
  int                 prog_len [NUM_TESTS];
  logic [`ADDR_W-1:0] exp_addr_tab [NUM_TESTS];
  bit                 exp_halt_tab [NUM_TESTS];
  bit                 exp_beep_tab [NUM_TESTS];
  string              name_tab [NUM_TESTS];
  int                 n_tests   = 0;
  int                 n_pass    = 0;
  int                 n_fail    = 0;
  int                 cycle_cnt = 0;

  chip8_cpu u_dut (
    .clk_in     (clk_in),
    .reset_i    (reset_i),
    .mem_rdata_i(mem_rdata_i),
    .mem_raddr_o(mem_raddr_o),
    .beep_o     (beep_o),
    .halt_o     (halt_o)
  );

  bind chip8_cpu chip8_props u_props (
    .clk_in     (clk_in),
    .reset_i    (reset_i),
    .mem_raddr_o(mem_raddr_o),
    .beep_o     (beep_o),
    .halt_o     (halt_o)
  );

  always #10 clk_in = ~clk_in;

  // program memory, one cycle read latency
  always @(posedge clk_in) begin
    mem_rdata_i <= mem[mem_raddr_o];
  end

  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: simulation ran past %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic add_test(input string name, input int n, input logic [255:0] words,
                          input logic [`ADDR_W-1:0] exp_addr, input bit exp_halt,
                          input bit exp_beep);
    for (int i = 0; i < n; i++) begin
      prog_tab[n_tests][i] = words[16*(n-1-i) +: 16]; // first word sits highest
    end
    prog_len[n_tests]     = n;
    exp_addr_tab[n_tests] = exp_addr;
    exp_halt_tab[n_tests] = exp_halt;
    exp_beep_tab[n_tests] = exp_beep;
    name_tab[n_tests]     = name;
    n_tests++;
  endtask

  task automatic load_program(input int t);
    logic [11:0] a;
    for (int i = 0; i < 4096; i++) begin
      a = 12'(i);
      mem[i] = 8'hE0 | {4'h0, a[3:0] ^ a[7:4] ^ a[11:8]}; // every word decodes as illegal
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      mem[`RESET_PC + 2*i]     = prog_tab[t][i][15:8];
      mem[`RESET_PC + 2*i + 1] = prog_tab[t][i][7:0];
    end
  endtask

  task automatic run_test(input int t);
    logic [`ADDR_W-1:0] prev_addr;
    logic [`ADDR_W-1:0] last_fetch;
    int                 cyc;
    int                 errs;
    bit                 looped;
    bit                 halted;

    @(posedge clk_in);
    reset_i <= 1'b1;
    load_program(t);
    repeat (16) @(posedge clk_in);
    reset_i <= 1'b0;
    prev_addr  = `RESET_PC;
    last_fetch = `RESET_PC;
    cyc        = 0;
    errs       = 0;
    looped     = 1'b0;
    halted     = 1'b0;
    while (!looped && !halted && cyc < TEST_CYCLES) begin
      @(negedge clk_in);
      cyc++;
      if (halt_o) begin
        halted = 1'b1;
      end else if (mem_raddr_o != prev_addr && !mem_raddr_o[0]) begin
        looped     = (mem_raddr_o == last_fetch); // same word fetched back to back
        last_fetch = mem_raddr_o;
      end
      prev_addr = mem_raddr_o;
    end

    if (exp_halt_tab[t]) begin
      assert (halted) else begin
        $display("%s: halt_o never rose within %0d cycles", name_tab[t], TEST_CYCLES);
        errs++;
      end
      if (halted) begin
        repeat (8) @(negedge clk_in);
        assert (halt_o) else begin
          $display("%s: halt_o dropped without a reset", name_tab[t]);
          errs++;
        end
      end
      assert (mem_raddr_o == exp_addr_tab[t]) else begin
        $display("[ERROR] %s: mem_raddr_o = 0x%03h, expected 0x%03h",
                 name_tab[t], mem_raddr_o, exp_addr_tab[t]);
        errs++;
      end
    end else begin
      assert (!halted) else begin
        $display("[ERROR] %s: halt_o = 0x1, expected 0x0 (mem_raddr_o = 0x%03h)",
                 name_tab[t], mem_raddr_o);
        errs++;
      end
      assert (looped || halted) else begin
        $display("%s: program reached no jump-to-self loop in %0d cycles",
                 name_tab[t], TEST_CYCLES);
        errs++;
      end
      if (looped) begin
        assert (last_fetch == exp_addr_tab[t]) else begin
          $display("[ERROR] %s: mem_raddr_o = 0x%03h, expected 0x%03h",
                   name_tab[t], last_fetch, exp_addr_tab[t]);
          errs++;
        end
        assert (beep_o == exp_beep_tab[t]) else begin
          $display("[ERROR] %s: beep_o = 0x%0h, expected 0x%0h",
                   name_tab[t], beep_o, exp_beep_tab[t]);
          errs++;
        end
        if (exp_beep_tab[t] && beep_o) begin
          cyc = 0;
          while (beep_o && cyc < BEEP_WAIT) begin
            @(negedge clk_in);
            cyc++;
          end
          assert (!beep_o) else begin
            $display("%s: beep_o still high %0d cycles after the loop end",
                     name_tab[t], BEEP_WAIT);
            errs++;
          end
        end
      end
    end

    $display("test %0d %-10s %s", t, name_tab[t], (errs == 0) ? "passed" : "failed");
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  initial begin
    // 7xkk wraps, 3xkk/4xkk/9xy0 skips, vf untouched by 7xkk
    add_test("load_add", 13,
             {16'h6AF0, 16'h7A25, 16'h3A15, 16'h1206, 16'h4A16, 16'h120A, 16'h6B15,
              16'h9AB0, 16'h1214, 16'h1212, 16'h3F00, 16'h1216, 16'h1218},
             12'h218, 1'b0, 1'b0);
    // F0+20 carries, 10-20 borrows, F0-20 via subn does not
    add_test("alu_flags", 16,
             {16'h61F0, 16'h6220, 16'h8124, 16'h3F01, 16'h1208, 16'h8125, 16'h3F00,
              16'h120E, 16'h31F0, 16'h1212, 16'h8217, 16'h3F01, 16'h1218, 16'h32D0,
              16'h121C, 16'h121E},
             12'h21E, 1'b0, 1'b0);
    // 81 >> 1 = 40 flag 1, 40 << 1 = 80 flag 0, 80 << 1 = 00 flag 1
    add_test("shifts", 16,
             {16'h6181, 16'h8116, 16'h3F01, 16'h1206, 16'h6340, 16'h5130, 16'h120C,
              16'h811E, 16'h3F00, 16'h1212, 16'h811E, 16'h3F01, 16'h1218, 16'h3100,
              16'h121C, 16'h121E},
             12'h21E, 1'b0, 1'b0);
    // call 212, return to 202, then B210 + V0 = 218
    add_test("call_jump", 13,
             {16'h2212, 16'h3542, 16'h1204, 16'hA300, 16'hF51E, 16'h0123, 16'h6008,
              16'hB210, 16'h1210, 16'h6542, 16'h00EE, 16'h1216, 16'h1218},
             12'h218, 1'b0, 1'b0);
    // dt = 3, st = 5, poll dt until zero
    add_test("timers", 8,
             {16'h6003, 16'hF015, 16'h6105, 16'hF118, 16'hF207, 16'h3200, 16'h1208,
              16'h120E},
             12'h20E, 1'b0, 1'b1);
    add_test("keypad_op", 2, {16'h6012, 16'hE09E}, 12'h203, 1'b1, 1'b0);
    add_test("bcd_op", 3, {16'h6177, 16'h7101, 16'hF033}, 12'h205, 1'b1, 1'b0);

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end
endmodule

/* tests/chip8_props.sv */
`include "chip8_defines.svh"

module chip8_props (
  input logic               clk_in,
  input logic               reset_i,
  input logic [`ADDR_W-1:0] mem_raddr_o,
  input logic               beep_o,
  input logic               halt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // only reset leaves HALT
  halt_held: assert property (@(posedge clk_in) halt_o && !reset_i |=> halt_o)
    else $error("halt_o dropped while reset_i was low");

  reset_clears: assert property (@(posedge clk_in) reset_i |=> !halt_o && !beep_o)
    else $error("halt_o or beep_o high in the cycle after reset");

  addr_frozen: assert property (@(posedge clk_in) halt_o && !reset_i |=> $stable(mem_raddr_o))
    else $error("mem_raddr_o moved while halted"); // low byte address of the bad opcode
endmodule

/* design/chip8_cpu.sv */
`include "chip8_defines.svh"

module chip8_cpu
  import chip8_isa_pkg::*;
(
  input  logic               clk_in,
  input  logic               reset_i,
  input  logic [`DATA_W-1:0] mem_rdata_i,
  output logic [`ADDR_W-1:0] mem_raddr_o,
  output logic               beep_o,
  output logic               halt_o
);
  logic               alu_start;
  alu_op_e            alu_op;
  logic [`DATA_W-1:0] alu_a;
  logic [`DATA_W-1:0] alu_b;
  logic [`ADDR_W-1:0] alu_b_long;
  logic [`DATA_W-1:0] alu_result;
  logic [`ADDR_W-1:0] alu_result_long;
  logic               alu_flag;
  logic               alu_done;

  chip8_reg_if u_reg_if ();

  chip8_sequencer u_seq (
    .clk_in           (clk_in),
    .reset_i          (reset_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_raddr_o      (mem_raddr_o),
    .halt_o           (halt_o),
    .regs             (u_reg_if),
    .alu_start_o      (alu_start),
    .alu_op_o         (alu_op),
    .alu_a_o          (alu_a),
    .alu_b_o          (alu_b),
    .alu_b_long_o     (alu_b_long),
    .alu_result_i     (alu_result),
    .alu_result_long_i(alu_result_long),
    .alu_flag_i       (alu_flag),
    .alu_done_i       (alu_done)
  );

  chip8_alu u_alu (
    .clk_in       (clk_in),
    .reset_i      (reset_i),
    .start_i      (alu_start),
    .op_i         (alu_op),
    .a_i          (alu_a),
    .b_i          (alu_b),
    .b_long_i     (alu_b_long),
    .result_o     (alu_result),
    .result_long_o(alu_result_long),
    .flag_o       (alu_flag),
    .done_o       (alu_done)
  );

  chip8_regfile u_regfile (
    .clk_in (clk_in),
    .reset_i(reset_i),
    .regs   (u_reg_if),
    .beep_o (beep_o)
  );
endmodule

/* design/chip8_sequencer.sv */
`include "chip8_defines.svh"

module chip8_sequencer
  import chip8_isa_pkg::*;
  import chip8_core_pkg::*;
(
  input  logic               clk_in,
  input  logic               reset_i,
  input  logic [`DATA_W-1:0] mem_rdata_i,
  output logic [`ADDR_W-1:0] mem_raddr_o,
  output logic               halt_o,
  chip8_reg_if.seq           regs,
  output logic               alu_start_o,
  output alu_op_e            alu_op_o,
  output logic [`DATA_W-1:0] alu_a_o,
  output logic [`DATA_W-1:0] alu_b_o,
  output logic [`ADDR_W-1:0] alu_b_long_o,
  input  logic [`DATA_W-1:0] alu_result_i,
  input  logic [`ADDR_W-1:0] alu_result_long_i,
  input  logic               alu_flag_i,
  input  logic               alu_done_i
);
  localparam int SP_W = $clog2(`STACK_DEPTH);

  seq_state_e         state_q;
  logic [`ADDR_W-1:0] pc_q;
  logic [`ADDR_W-1:0] pc_plus2;
  logic [`ADDR_W-1:0] pc_plus4;
  logic [`ADDR_W-1:0] stack_q [`STACK_DEPTH];
  logic [SP_W-1:0]    sp_q;
  logic [`DATA_W-1:0] hi_q;
  opcode_u            word;

  // decoder outputs, latched in DECODE
  instr_class_e       d_cls;
  logic               d_illegal;
  alu_op_e            d_op;
  logic [`DATA_W-1:0] d_a;
  logic [`DATA_W-1:0] d_b;
  logic [`ADDR_W-1:0] d_b_long;
  logic [`DATA_W-1:0] d_val;
  logic               d_ld_v;
  logic               d_ld_i;
  logic               d_ld_dt;
  logic               d_ld_st;
  logic               d_from_dt;
  logic               d_to_i;
  logic               d_flag_we;

  instr_class_e       cls_q;
  logic [3:0]         dst_q;
  logic [`ADDR_W-1:0] nnn_q;
  logic [`DATA_W-1:0] val_q;
  logic               ld_v_q;
  logic               ld_i_q;
  logic               ld_dt_q;
  logic               ld_st_q;
  logic               from_dt_q;
  logic               to_i_q;
  logic               flag_we_q;
  logic               exec_ld;
  logic               in_wb;

  assign word     = {hi_q, mem_rdata_i}; // low byte arrives in DECODE
  assign pc_plus2 = pc_q + `ADDR_W'(2);
  assign pc_plus4 = pc_q + `ADDR_W'(4);
  assign halt_o   = (state_q == HALT);

  // BNNN reads V0 through the x port
  assign regs.rd_x_addr = (word.nib.top == 4'hB) ? 4'h0 : word.nib.x;
  assign regs.rd_y_addr = word.nib.y;

  always_comb begin
    d_cls     = NOP;
    d_illegal = 1'b0;
    d_op      = ADD;
    d_a       = regs.rd_x_data;
    d_b       = regs.rd_y_data;
    d_b_long  = word.imm.nnn;
    d_val     = regs.rd_x_data;
    d_ld_v    = 1'b0;
    d_ld_i    = 1'b0;
    d_ld_dt   = 1'b0;
    d_ld_st   = 1'b0;
    d_from_dt = 1'b0;
    d_to_i    = 1'b0;
    d_flag_we = 1'b0;
    case (word.nib.top)
      4'h0: d_cls = (word.imm.nnn == 12'h0EE) ? RET : NOP;
      4'h1: d_cls = JP;
      4'h2: d_cls = CALL;
      4'h3, 4'h4: begin
        d_cls = CALU;
        d_op  = (word.nib.top == 4'h3) ? SE : SNE;
        d_b   = word.imm.nnn[7:0];
      end
      4'h5, 4'h9: begin
        d_cls     = CALU;
        d_op      = (word.nib.top == 4'h5) ? SE : SNE;
        d_illegal = (word.nib.n != 4'h0);
      end
      4'h6: begin
        d_cls  = LD;
        d_ld_v = 1'b1;
        d_val  = word.imm.nnn[7:0];
      end
      4'h7: begin
        d_cls = ALU; // no flag on 7xkk
        d_b   = word.imm.nnn[7:0];
      end
      4'h8: begin
        d_cls     = ALU;
        d_flag_we = 1'b1;
        case (word.nib.n)
          4'h0: begin
            d_cls     = LD;
            d_ld_v    = 1'b1;
            d_val     = regs.rd_y_data;
            d_flag_we = 1'b0;
          end
          4'h1: d_op = OR;
          4'h2: d_op = AND;
          4'h3: d_op = XOR;
          4'h4: d_op = ADD;
          4'h5: d_op = SUB;
          4'h7: d_op = SUBN;
          4'h6, 4'hE: begin
            d_op = (word.nib.n == 4'h6) ? SHR : SHL;
            d_a  = regs.rd_y_data; // shifts vy, as the original interpreter
          end
          default: d_illegal = 1'b1;
        endcase
      end
      4'hA: begin
        d_cls  = LD;
        d_ld_i = 1'b1;
      end
      4'hB: begin
        d_cls = ALUJ;
        d_op  = ADDL;
      end
      4'hF: begin
        d_cls = LD;
        case (word.imm.nnn[7:0])
          8'h07: begin
            d_ld_v    = 1'b1;
            d_from_dt = 1'b1;
          end
          8'h15: d_ld_dt = 1'b1;
          8'h18: d_ld_st = 1'b1;
          8'h1E: begin
            d_cls    = ALU;
            d_op     = ADDL;
            d_b_long = regs.i_q;
            d_to_i   = 1'b1;
          end
          default: d_illegal = 1'b1;
        endcase
      end
      default: d_illegal = 1'b1; // C, D, E are not implemented
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (reset_i) begin
      state_q     <= FETCH_HI;
      pc_q        <= `RESET_PC;
      sp_q        <= '0;
      mem_raddr_o <= `RESET_PC;
      alu_start_o <= 1'b0;
    end else begin
      alu_start_o <= 1'b0;
      case (state_q)
        FETCH_HI: begin
          mem_raddr_o <= pc_q + 1'b1;
          state_q     <= FETCH_LO;
        end
        FETCH_LO: state_q <= DECODE;
        DECODE: begin
          if (d_illegal) begin
            state_q <= HALT;
          end else begin
            state_q     <= EXEC;
            alu_start_o <= (d_cls == ALU) || (d_cls == CALU) || (d_cls == ALUJ);
          end
        end
        EXEC: begin
          state_q <= CLEANUP;
          case (cls_q)
            LD: pc_q <= pc_plus2;
            ALU: begin
              state_q <= alu_done_i ? WB : EXEC;
              pc_q    <= alu_done_i ? pc_plus2 : pc_q;
            end
            CALU: begin
              state_q <= alu_done_i ? CLEANUP : EXEC;
              if (alu_done_i) begin
                pc_q <= (alu_result_i != '0) ? pc_plus4 : pc_plus2;
              end
            end
            ALUJ: begin
              state_q <= alu_done_i ? CLEANUP : EXEC;
              pc_q    <= alu_done_i ? alu_result_long_i : pc_q;
            end
            JP: pc_q <= nnn_q;
            CALL: begin
              sp_q <= sp_q + 1'b1;
              pc_q <= nnn_q;
            end
            RET: begin
              sp_q <= sp_q - 1'b1;
              pc_q <= stack_q[sp_q - 1'b1];
            end
            default: pc_q <= pc_plus2;
          endcase
        end
        WB: state_q <= CLEANUP;
        CLEANUP: begin
          mem_raddr_o <= pc_q;
          state_q     <= FETCH_HI;
        end
        default: state_q <= HALT; // only reset leaves
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state_q == FETCH_LO) begin
      hi_q <= mem_rdata_i;
    end
    if (state_q == DECODE) begin
      cls_q        <= d_cls;
      dst_q        <= word.nib.x;
      nnn_q        <= word.imm.nnn;
      val_q        <= d_val;
      ld_v_q       <= d_ld_v;
      ld_i_q       <= d_ld_i;
      ld_dt_q      <= d_ld_dt;
      ld_st_q      <= d_ld_st;
      from_dt_q    <= d_from_dt;
      to_i_q       <= d_to_i;
      flag_we_q    <= d_flag_we;
      alu_op_o     <= d_op;
      alu_a_o      <= d_a;
      alu_b_o      <= d_b;
      alu_b_long_o <= d_b_long;
    end
    if (state_q == EXEC && cls_q == CALL) begin
      stack_q[sp_q] <= pc_plus2;
    end
  end

  assign exec_ld = (state_q == EXEC) && (cls_q == LD);
  assign in_wb   = (state_q == WB);

  always_comb begin
    regs.v_we    = (exec_ld && ld_v_q) || (in_wb && !to_i_q);
    regs.v_waddr = dst_q;
    if (in_wb) begin
      regs.v_wdata = alu_result_i;
    end else begin
      regs.v_wdata = from_dt_q ? regs.dt_q : val_q;
    end
    regs.vf_we   = in_wb && flag_we_q;
    regs.vf_data = alu_flag_i;
    regs.i_we    = (exec_ld && ld_i_q) || (in_wb && to_i_q);
    regs.i_wdata = in_wb ? alu_result_long_i : nnn_q;
    regs.dt_we   = exec_ld && ld_dt_q;
    regs.st_we   = exec_ld && ld_st_q;
  end
endmodule

/* design/chip8_regfile.sv */
`include "chip8_defines.svh"

module chip8_regfile (
  input  logic      clk_in,
  input  logic      reset_i,
  chip8_reg_if.regs regs,
  output logic      beep_o
);
  localparam int TICK_W = $clog2(`TIMER_DIV);

  logic [`DATA_W-1:0] v_q [16];
  logic [`ADDR_W-1:0] idx_q;
  logic [`DATA_W-1:0] dt_cnt_q;
  logic [`DATA_W-1:0] st_cnt_q;
  logic [TICK_W-1:0]  tick_cnt_q;
  logic               tick;

  assign tick = (tick_cnt_q == TICK_W'(`TIMER_DIV - 1));

  always_ff @(posedge clk_in) begin
    if (reset_i) begin
      for (int r = 0; r < 16; r++) begin
        v_q[r] <= '0;
      end
      idx_q <= '0;
    end else begin
      if (regs.v_we) begin
        v_q[regs.v_waddr] <= regs.v_wdata;
      end
      if (regs.vf_we) begin
        v_q[15] <= {{(`DATA_W-1){1'b0}}, regs.vf_data}; // overrides a vf write above
      end
      if (regs.i_we) begin
        idx_q <= regs.i_wdata;
      end
    end
  end

  // 60 Hz style tick divider
  always_ff @(posedge clk_in) begin
    if (reset_i) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= '0;
    end else begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (reset_i) begin
      dt_cnt_q <= '0;
      st_cnt_q <= '0;
    end else begin
      if (regs.dt_we) begin
        dt_cnt_q <= regs.v_wdata;
      end else if (tick && dt_cnt_q != '0) begin
        dt_cnt_q <= dt_cnt_q - 1'b1;
      end
      if (regs.st_we) begin
        st_cnt_q <= regs.v_wdata;
      end else if (tick && st_cnt_q != '0) begin
        st_cnt_q <= st_cnt_q - 1'b1;
      end
    end
  end

  assign regs.rd_x_data = v_q[regs.rd_x_addr];
  assign regs.rd_y_data = v_q[regs.rd_y_addr];
  assign regs.i_q       = idx_q;
  assign regs.dt_q      = dt_cnt_q;
  assign beep_o         = (st_cnt_q != '0);
endmodule

/* design/chip8_alu.sv */
`include "chip8_defines.svh"

module chip8_alu
  import chip8_isa_pkg::*;
(
  input  logic               clk_in,
  input  logic               reset_i,
  input  logic               start_i,
  input  alu_op_e            op_i,
  input  logic [`DATA_W-1:0] a_i,
  input  logic [`DATA_W-1:0] b_i,
  input  logic [`ADDR_W-1:0] b_long_i,
  output logic [`DATA_W-1:0] result_o,
  output logic [`ADDR_W-1:0] result_long_o,
  output logic               flag_o,
  output logic               done_o
);
  logic [`DATA_W:0] sum;
  logic [`DATA_W:0] diff;
  logic [`DATA_W:0] diff_n;

  assign sum    = {1'b0, a_i} + {1'b0, b_i};
  assign diff   = {1'b0, a_i} - {1'b0, b_i};
  assign diff_n = {1'b0, b_i} - {1'b0, a_i};

  always_ff @(posedge clk_in) begin
    if (reset_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= start_i;
    end
  end

  // outputs hold until the next start
  always_ff @(posedge clk_in) begin
    if (start_i) begin
      flag_o        <= 1'b0;
      result_o      <= '0;
      result_long_o <= b_long_i + {{(`ADDR_W-`DATA_W){1'b0}}, a_i};
      case (op_i)
        ADD: begin
          result_o <= sum[`DATA_W-1:0];
          flag_o   <= sum[`DATA_W]; // carry
        end
        SUB: begin
          result_o <= diff[`DATA_W-1:0];
          flag_o   <= ~diff[`DATA_W]; // no borrow
        end
        SUBN: begin
          result_o <= diff_n[`DATA_W-1:0];
          flag_o   <= ~diff_n[`DATA_W];
        end
        OR:  result_o <= a_i | b_i;
        AND: result_o <= a_i & b_i;
        XOR: result_o <= a_i ^ b_i;
        SHR: begin
          result_o <= a_i >> 1;
          flag_o   <= a_i[0];
        end
        SHL: begin
          result_o <= a_i << 1;
          flag_o   <= a_i[`DATA_W-1];
        end
        SE:  result_o <= {{(`DATA_W-1){1'b0}}, a_i == b_i};
        SNE: result_o <= {{(`DATA_W-1){1'b0}}, a_i != b_i};
        default: ; // ADDL only uses the long result
      endcase
    end
  end
endmodule

/* design/chip8_reg_if.sv */
`include "chip8_defines.svh"

interface chip8_reg_if;
  logic [3:0]         rd_x_addr;
  logic [3:0]         rd_y_addr;
  logic [`DATA_W-1:0] rd_x_data;
  logic [`DATA_W-1:0] rd_y_data;
  logic               v_we;
  logic [3:0]         v_waddr;
  logic [`DATA_W-1:0] v_wdata; // also the timer load value
  logic               vf_we;
  logic               vf_data;
  logic               i_we;
  logic [`ADDR_W-1:0] i_wdata;
  logic               dt_we;
  logic               st_we;
  logic [`ADDR_W-1:0] i_q;
  logic [`DATA_W-1:0] dt_q;

  modport seq (
    output rd_x_addr, rd_y_addr, v_we, v_waddr, v_wdata, vf_we, vf_data,
    output i_we, i_wdata, dt_we, st_we,
    input  rd_x_data, rd_y_data, i_q, dt_q
  );

  modport regs (
    input  rd_x_addr, rd_y_addr, v_we, v_waddr, v_wdata, vf_we, vf_data,
    input  i_we, i_wdata, dt_we, st_we,
    output rd_x_data, rd_y_data, i_q, dt_q
  );
endinterface

/* design/chip8_core_pkg.sv */
package chip8_core_pkg;

  typedef enum logic [2:0] {
    FETCH_HI,
    FETCH_LO,
    DECODE,
    EXEC,
    WB,
    CLEANUP,
    HALT
  } seq_state_e;

  // what EXEC does with a decoded opcode
  typedef enum logic [2:0] {
    LD,
    ALU,  // result written back in WB
    CALU, // conditional skip
    ALUJ, // computed jump
    JP,
    CALL,
    RET,
    NOP
  } instr_class_e;

endpackage

/* design/chip8_isa_pkg.sv */
package chip8_isa_pkg;

  // nibble view: top, x, y, n
  typedef struct packed {
    logic [3:0] top;
    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] n;
  } opcode_nib_s;

  // immediate view, kk is nnn[7:0]
  typedef struct packed {
    logic [3:0]  top;
    logic [11:0] nnn;
  } opcode_imm_s;

  typedef union packed {
    opcode_nib_s nib;
    opcode_imm_s imm;
  } opcode_u;

  typedef enum logic [3:0] {
    ADD,
    ADDL, // byte into 12 bits
    SUB,
    SUBN,
    OR,
    AND,
    XOR,
    SHR,
    SHL,
    SE,
    SNE
  } alu_op_e;

endpackage

/* design/chip8_defines.svh */
`ifndef CHIP8_DEFINES_SVH
`define CHIP8_DEFINES_SVH

// program address width
`define ADDR_W 12

// byte width of memory and V registers
`define DATA_W 8

`define RESET_PC 12'h200 // first opcode lives here

// return stack entries
`define STACK_DEPTH 16

// clocks per delay/sound timer tick
`define TIMER_DIV 200

`endif
